// File: hw/tlbPkg.sv
`default_nettype none

package tlbPkg;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Translation scheme as held in the satp MODE field
  // Sv32 is not built, so only these three codes are legal
  typedef enum logic [3:0] {
    modeBare = 4'd0,
    modeSv39 = 4'd8,
    modeSv48 = 4'd9
  } satpModeE;

  // Privilege levels in the core's two-bit encoding
  localparam logic [1:0] privModeU = 2'd0;
  localparam logic [1:0] privModeS = 2'd1;
  localparam logic [1:0] privModeM = 2'd3;

  // Bit positions within the low byte of a PTE
  // V sits at bit 0 and G at bit 5 and neither is looked at here
  localparam int pteBitR = 1;
  localparam int pteBitW = 2;
  localparam int pteBitX = 3;
  localparam int pteBitU = 4;
  localparam int pteBitA = 6;
  localparam int pteBitD = 7;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Status and satp fields the translation depends on
  typedef struct packed {
    satpModeE   satpMode;
    logic       mxr;
    logic       sum;
    logic       mprv;
    logic [1:0] mpp;
    logic [1:0] privMode;
  } tlbCsrT;

  // A load or store address from the core
  typedef struct packed {
    logic [63:0] vaddr;
    logic        read;
    logic        write;
    logic        disableTranslation;
  } tlbReqT;

  // One 4 KiB mapping to load into the table
  // Under Sv39 only vpn[26:0] is meaningful and vpn[35:27] is zero
  typedef struct packed {
    logic [35:0] vpn;
    logic [43:0] ppn;
    logic [7:0]  pteBits;
  } tlbFillT;

  // Request plus the decisions made in the first stage
  typedef struct packed {
    tlbReqT     req;
    logic [1:0] effPriv;
    logic       translate;
    logic       sv39;
  } tlbStage1T;

  // First-stage bundle plus the outcome of the table lookup
  typedef struct packed {
    tlbStage1T   s1;
    logic        camHit;
    logic [43:0] ppn;
    logic [7:0]  pteBits;
  } tlbStage2T;

  // Result handed back to the load/store unit
  typedef struct packed {
    logic        hit;
    logic        miss;
    logic        pageFault;
    logic        translate;
    logic [55:0] paddr;
  } tlbRespT;

endpackage

`default_nettype wire

// File: hw/tlbRequestStage.sv
`timescale 1ns/1ps
`default_nettype none

module tlbRequestStage
  import tlbPkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  tlbCsrT    csr,
  input  logic      reqValid,
  input  tlbReqT    req,
  output logic      s1Valid,
  output tlbStage1T s1
);

  // Privilege the access is checked against
  logic [1:0] effPriv;

  // High when the address goes through the page tables
  logic translate;

  // Selects the 27-bit VPN compare in the lookup stage
  logic sv39;

  //////////////////////////////////////////////////////////////
  // Mode and privilege decode
  //////////////////////////////////////////////////////////////

  // With MPRV set, loads and stores run at the privilege held in MPP
  // This is a data-side block, so the rule applies unconditionally
  assign effPriv = csr.mprv ? csr.mpp : csr.privMode;

  // M mode always sees physical addresses, as does Bare mode
  // The core may also bypass translation per request, e.g. for the walker
  assign translate = (csr.satpMode != modeBare) &&
                     (effPriv != privModeM) &&
                     !req.disableTranslation;

  // Anything translating that is not Sv39 is treated as Sv48
  assign sv39 = (csr.satpMode == modeSv39);

  //////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////

  // Valid is the only control state in this stage
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= reqValid;
    end
  end

  // Payload only moves when a request is strobed
  always_ff @(posedge clk) begin
    if (reqValid) begin
      s1.req       <= req;
      s1.effPriv   <= effPriv;
      s1.translate <= translate;
      s1.sv39      <= sv39;
    end
  end

  // The satp mode must be one of the three built schemes whenever the core
  // issues an access; an Sv32 or reserved code would be read as Sv48 downstream
  assert property (@(posedge clk) disable iff (!rstN)
    reqValid |-> csr.satpMode inside {modeBare, modeSv39, modeSv48})
    else $error("satp mode 0x%0h is not a supported scheme", csr.satpMode);

endmodule

`default_nettype wire

// File: hw/tlbCam.sv
`timescale 1ns/1ps
`default_nettype none

module tlbCam
  import tlbPkg::*;
#(
  parameter int TLB_ENTRIES = 8
) (
  input  logic      clk,
  input  logic      rstN,
  input  logic      s1Valid,
  input  tlbStage1T s1,
  input  logic      fillValid,
  input  tlbFillT   fill,
  input  logic      flush,
  output logic      s2Valid,
  output tlbStage2T s2
);

  // Width of the replacement pointer
  localparam int PTR_W = $clog2(TLB_ENTRIES);

  // Round-robin replacement only wraps cleanly on a power of two
  if (TLB_ENTRIES < 2 || (TLB_ENTRIES & (TLB_ENTRIES - 1)) != 0) begin : gBadEntries
    $error("TLB_ENTRIES must be a power of two and at least 2");
  end

  // Entry state of the table
  logic [TLB_ENTRIES-1:0] entryValid;
  logic [35:0]            entryVpn [TLB_ENTRIES];
  logic [43:0]            entryPpn [TLB_ENTRIES];
  logic [7:0]             entryPte [TLB_ENTRIES];

  // Next entry to be overwritten by a fill
  logic [PTR_W-1:0] fillPtr;

  // One bit per entry that matches the current lookup
  logic [TLB_ENTRIES-1:0] matchVec;

  // Translation of the selected entry
  logic [43:0] hitPpn;
  logic [7:0]  hitPte;

  //////////////////////////////////////////////////////////////
  // Fill, flush and replacement
  //////////////////////////////////////////////////////////////

  // A flush wins over a fill in the same cycle
  // The fill is then dropped and the pointer stays where it is
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      entryValid <= '0;
      fillPtr    <= '0;
    end else if (flush) begin
      entryValid <= '0;
    end else if (fillValid) begin
      entryValid[fillPtr] <= 1'b1;
      fillPtr             <= fillPtr + 1'b1;
    end
  end

  // Mapping fields follow the same write rule as the valid bit
  always_ff @(posedge clk) begin
    if (fillValid && !flush) begin
      entryVpn[fillPtr] <= fill.vpn;
      entryPpn[fillPtr] <= fill.ppn;
      entryPte[fillPtr] <= fill.pteBits;
    end
  end

  //////////////////////////////////////////////////////////////
  // Associative match
  //////////////////////////////////////////////////////////////

  // VPN[26:0] covers Sv39 and is always compared
  // VPN[35:27] only takes part under Sv48
  for (genvar i = 0; i < TLB_ENTRIES; i++) begin : gMatch
    logic lowEq;
    logic highEq;

    assign lowEq       = (entryVpn[i][26:0] == s1.req.vaddr[38:12]);
    assign highEq      = (entryVpn[i][35:27] == s1.req.vaddr[47:39]);
    assign matchVec[i] = entryValid[i] && lowEq && (s1.sv39 || highEq);
  end

  // Walk from the top so that the lowest matching index is the one kept
  always_comb begin
    hitPpn = '0;
    hitPte = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (matchVec[i]) begin
        hitPpn = entryPpn[i];
        hitPte = entryPte[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s2Valid <= 1'b0;
    end else begin
      s2Valid <= s1Valid;
    end
  end

  // Lookup result travels with the request it belongs to
  always_ff @(posedge clk) begin
    if (s1Valid) begin
      s2.s1      <= s1;
      s2.camHit  <= |matchVec;
      s2.ppn     <= hitPpn;
      s2.pteBits <= hitPte;
    end
  end

  // The fill source must never load a page that is already resident,
  // otherwise two entries would answer for one address
  assert property (@(posedge clk) disable iff (!rstN)
    s1Valid |-> $onehot0(matchVec))
    else $error("Multiple TLB entries match vaddr 0x%0h", s1.req.vaddr);

endmodule

`default_nettype wire

// File: hw/tlbControl.sv
`timescale 1ns/1ps
`default_nettype none

module tlbControl
  import tlbPkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  logic      s2Valid,
  input  tlbStage2T s2,
  input  tlbCsrT    csr,
  input  logic      flush,
  output logic      respValid,
  output tlbRespT   resp
);

  // Virtual address of the access under check
  logic [63:0] va;

  // A read or a write is actually being made
  logic access;

  // Unpacked PTE permission and status bits
  logic pteR;
  logic pteW;
  logic pteX;
  logic pteU;
  logic pteA;
  logic pteD;

  // Individual fault causes
  logic improperPriv;
  logic invalidRead;
  logic invalidWrite;
  logic daFault;
  logic upperFault;

  // Sign extension checks for each scheme
  logic canon39;
  logic canon48;

  // Response before the output register
  tlbRespT respNext;

  assign va     = s2.s1.req.vaddr;
  assign access = s2.s1.req.read || s2.s1.req.write;

  assign pteR = s2.pteBits[pteBitR];
  assign pteW = s2.pteBits[pteBitW];
  assign pteX = s2.pteBits[pteBitX];
  assign pteU = s2.pteBits[pteBitU];
  assign pteA = s2.pteBits[pteBitA];
  assign pteD = s2.pteBits[pteBitD];

  //////////////////////////////////////////////////////////////
  // Permission checks
  //////////////////////////////////////////////////////////////

  // U mode may only touch U pages
  // S mode may touch U pages only while SUM is set
  assign improperPriv = ((s2.s1.effPriv == privModeU) && !pteU) ||
                        ((s2.s1.effPriv == privModeS) && pteU && !csr.sum);

  // With MXR set, executable pages also count as readable
  assign invalidRead = s2.s1.req.read && !pteR && !(csr.mxr && pteX);

  assign invalidWrite = s2.s1.req.write && !pteW;

  // A and D are not updated in hardware, so software takes a fault instead
  assign daFault = !pteA || (s2.s1.req.write && !pteD);

  // Bits above bit 38 under Sv39 or above bit 47 under Sv48 must copy that bit
  assign canon39    = (&va[63:38]) || !(|va[63:38]);
  assign canon48    = (&va[63:47]) || !(|va[63:47]);
  assign upperFault = s2.s1.sv39 ? !canon39 : !canon48;

  //////////////////////////////////////////////////////////////
  // Response forming
  //////////////////////////////////////////////////////////////

  // Hit does not depend on translate, so a Bare access can still report one
  assign respNext.hit = s2.camHit && access;

  // Flush is sampled in the cycle the response is formed, so the response
  // registered at the flush edge never asks for a walk of stale state
  assign respNext.miss = !respNext.hit && !flush && s2.s1.translate && access;

  assign respNext.pageFault = s2.s1.translate && respNext.hit &&
                              (improperPriv || invalidRead || invalidWrite ||
                               daFault || upperFault);

  assign respNext.translate = s2.s1.translate;

  // 44-bit PPN over the page offset gives the 56-bit physical address
  assign respNext.paddr = s2.s1.translate ? {s2.ppn, va[11:0]} : va[55:0];

  //////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      respValid <= 1'b0;
    end else begin
      respValid <= s2Valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2Valid) begin
      resp <= respNext;
    end
  end

  // A presented response never reports a hit and a miss together
  assert property (@(posedge clk) disable iff (!rstN)
    respValid |-> !(resp.hit && resp.miss))
    else $error("Response 0x%0h reports hit and miss together", resp.paddr);

endmodule

`default_nettype wire

// File: hw/dataTlb.sv
`timescale 1ns/1ps
`default_nettype none

module dataTlb
  import tlbPkg::*;
#(
  parameter int TLB_ENTRIES = 8
) (
  input  logic    clk,
  input  logic    rstN,
  input  tlbCsrT  csr,
  input  logic    reqValid,
  input  tlbReqT  req,
  input  logic    fillValid,
  input  tlbFillT fill,
  input  logic    flush,
  output logic    respValid,
  output tlbRespT resp
);

  // Request stage to lookup stage
  logic      s1Valid;
  tlbStage1T s1;

  // Lookup stage to check stage
  logic      s2Valid;
  tlbStage2T s2;

  ////////////////////////////////////////////////////////////
  // Three-stage chain, one cycle per stage
  ////////////////////////////////////////////////////////////

  // Decodes privilege and translate for the incoming access
  tlbRequestStage requestStage (
    .clk      (clk),
    .rstN     (rstN),
    .csr      (csr),
    .reqValid (reqValid),
    .req      (req),
    .s1Valid  (s1Valid),
    .s1       (s1)
  );

  // Holds the entries and looks the page up
  tlbCam #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) cam (
    .clk       (clk),
    .rstN      (rstN),
    .s1Valid   (s1Valid),
    .s1        (s1),
    .fillValid (fillValid),
    .fill      (fill),
    .flush     (flush),
    .s2Valid   (s2Valid),
    .s2        (s2)
  );

  // Hit, miss and fault decision plus the physical address
  tlbControl control (
    .clk       (clk),
    .rstN      (rstN),
    .s2Valid   (s2Valid),
    .s2        (s2),
    .csr       (csr),
    .flush     (flush),
    .respValid (respValid),
    .resp      (resp)
  );

endmodule

`default_nettype wire

// File: tests/tlbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tlbClock #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rstN
);

  // Free running 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset is released on a rising edge, like every other DUT input
  initial begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/dataTlbChecks.sv
`timescale 1ns/1ps
`default_nettype none

module dataTlbChecks
  import tlbPkg::*;
#(
  parameter int TLB_ENTRIES = 8
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  tlbCsrT                       csr,
  input  logic                         reqValid,
  input  tlbReqT                       req,
  input  logic                         flush,
  input  logic                         respValid,
  input  tlbRespT                      resp,
  input  logic [TLB_ENTRIES-1:0]       shadowValid,
  input  tlbFillT [TLB_ENTRIES-1:0]    shadowEntry,
  output logic                         checkError
);

  // Model pipeline, one slot per DUT stage
  logic        p1Valid;
  logic        p2Valid;
  logic        p3Valid;
  tlbCsrT      p1Csr;
  tlbCsrT      p2Csr;
  tlbReqT      p1Req;
  tlbReqT      p2Req;
  logic        p2Found;
  logic [43:0] p2Ppn;
  logic [7:0]  p2Pte;
  tlbRespT     p3Exp;

  initial checkError = 1'b0;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Looks the request up in the shadow table as it stands when the CAM matches
  task automatic lookupShadow(input tlbCsrT c, input tlbReqT r);
    logic match;
    p2Found = 1'b0;
    p2Ppn   = '0;
    p2Pte   = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // Sv39 compares 27 VPN bits and Sv48 compares all 36
      if (c.satpMode == modeSv39) match = shadowEntry[i].vpn[26:0] == r.vaddr[38:12];
      else match = shadowEntry[i].vpn == r.vaddr[47:12];
      if (shadowValid[i] && match && !p2Found) begin
        p2Found = 1'b1;
        p2Ppn   = shadowEntry[i].ppn;
        p2Pte   = shadowEntry[i].pteBits;
      end
    end
  endtask

  // Expected response built straight from the hit, miss and fault rules
  function automatic tlbRespT predictResp(input tlbCsrT c, input tlbReqT r,
                                          input logic found, input logic [43:0] ppn,
                                          input logic [7:0] pte, input logic flushNow);
    tlbRespT    e;
    logic [1:0] priv;
    logic       xlate;
    logic       anyAccess;
    logic       canonical;
    logic       privBad;
    logic       readBad;
    logic       writeBad;
    logic       accessBad;
    priv      = c.mprv ? c.mpp : c.privMode;
    xlate     = (c.satpMode != modeBare) && (priv != privModeM) && !r.disableTranslation;
    anyAccess = r.read || r.write;
    // Upper bits must all repeat the top VPN bit of the scheme
    if (c.satpMode == modeSv39) canonical = r.vaddr[63:39] == {25{r.vaddr[38]}};
    else canonical = r.vaddr[63:48] == {16{r.vaddr[47]}};
    privBad = (priv == privModeU) ? !pte[pteBitU] :
              ((priv == privModeS) && pte[pteBitU] && !c.sum);
    readBad   = r.read && !(pte[pteBitR] || (c.mxr && pte[pteBitX]));
    writeBad  = r.write && !pte[pteBitW];
    accessBad = !pte[pteBitA] || (r.write && !pte[pteBitD]);
    e.hit       = found && anyAccess;
    e.miss      = !e.hit && xlate && anyAccess && !flushNow;
    e.pageFault = xlate && e.hit && (privBad || readBad || writeBad || accessBad || !canonical);
    e.translate = xlate;
    e.paddr     = xlate ? {ppn, r.vaddr[11:0]} : r.vaddr[55:0];
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////

  // Compares one response field with its expected value
  task automatic expectField(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (!checkError) begin
      assert (got === exp) else begin
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        checkError = 1'b1;
      end
    end
  endtask

  // A response must appear exactly when a request entered three edges ago
  task automatic checkResponse();
    expectField("respValid", respValid, p3Valid);
    if (p3Valid) begin
      expectField("resp.hit", resp.hit, p3Exp.hit);
      expectField("resp.miss", resp.miss, p3Exp.miss);
      expectField("resp.pageFault", resp.pageFault, p3Exp.pageFault);
      expectField("resp.translate", resp.translate, p3Exp.translate);
      // The PPN of a translating miss carries no meaning
      if (p3Exp.hit || !p3Exp.translate) expectField("resp.paddr", resp.paddr, p3Exp.paddr);
    end
  endtask

  // Slots advance from the back so each reads its neighbour's old contents
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      p1Valid = 1'b0;
      p2Valid = 1'b0;
      p3Valid = 1'b0;
    end else begin
      checkResponse();
      p3Valid = p2Valid;
      if (p2Valid) p3Exp = predictResp(p2Csr, p2Req, p2Found, p2Ppn, p2Pte, flush);
      p2Valid = p1Valid;
      if (p1Valid) begin
        p2Csr = p1Csr;
        p2Req = p1Req;
        lookupShadow(p1Csr, p1Req);
      end
      p1Valid = reqValid;
      p1Csr   = csr;
      p1Req   = req;
    end
  end

endmodule

`default_nettype wire

// File: tests/dataTlbTb.sv
`timescale 1ns/1ps
`default_nettype none

module dataTlbTb;
  import tlbPkg::*;

  localparam int TLB_ENTRIES    = 8;
  localparam int PTR_W          = $clog2(TLB_ENTRIES);
  localparam int RANDOM_ROUNDS  = 200;
  // Roughly twice the length of the whole stimulus
  localparam int TIMEOUT_CYCLES = 4000;
  // V, R, W, A and D set on a supervisor page
  localparam logic [7:0] PTE_RW = 8'hC7;

  logic    clk;
  logic    rstN;
  tlbCsrT  csr;
  logic    reqValid;
  tlbReqT  req;
  logic    fillValid;
  tlbFillT fill;
  logic    flush;
  logic    respValid;
  tlbRespT resp;

  // Shadow of the entry table and its replacement pointer
  logic [TLB_ENTRIES-1:0]    shadowValid;
  tlbFillT [TLB_ENTRIES-1:0] shadowEntry;
  logic [PTR_W-1:0]          shadowPtr;

  logic checkError;
  int   cycleCount = 0;
  int   inFlight;

  tlbClock #(.RESET_CYCLES(4)) clockGen (.clk(clk), .rstN(rstN));

  dataTlb #(.TLB_ENTRIES(TLB_ENTRIES)) dataTlb_inst (
    .clk(clk), .rstN(rstN), .csr(csr), .reqValid(reqValid), .req(req),
    .fillValid(fillValid), .fill(fill), .flush(flush),
    .respValid(respValid), .resp(resp)
  );

  dataTlbChecks #(.TLB_ENTRIES(TLB_ENTRIES)) checks (
    .clk(clk), .rstN(rstN), .csr(csr), .reqValid(reqValid), .req(req), .flush(flush),
    .respValid(respValid), .resp(resp), .shadowValid(shadowValid),
    .shadowEntry(shadowEntry), .checkError(checkError)
  );

  ////////////////////////////////////////////////////////////
  // Shadow state and run control
  ////////////////////////////////////////////////////////////

  // A flush clears every entry and beats a fill
  // A fill takes the entry under the pointer and moves the pointer on
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shadowValid <= '0;
      shadowPtr   <= '0;
    end else if (flush) begin
      shadowValid <= '0;
    end else if (fillValid) begin
      shadowValid[shadowPtr] <= 1'b1;
      shadowEntry[shadowPtr] <= fill;
      shadowPtr              <= shadowPtr + 1'b1;
    end
  end

  // Requests accepted but not yet answered
  always @(posedge clk or negedge rstN) begin
    if (!rstN) inFlight <= 0;
    else inFlight <= inFlight + int'(reqValid) - int'(respValid);
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Run stopped");
  endtask

  always @(posedge checkError) failRun("Stopping at the first response mismatch");

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) failRun("Timeout, the stimulus did not finish in time");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // All strobes drop unless the calling task raises one again
  task automatic stepIdle();
    @(posedge clk);
    reqValid  <= 1'b0;
    fillValid <= 1'b0;
    flush     <= 1'b0;
  endtask

  task automatic sendReq(input logic [63:0] va, input logic rd, input logic wr, input logic dis);
    stepIdle();
    reqValid                <= 1'b1;
    req.vaddr               <= va;
    req.read                <= rd;
    req.write               <= wr;
    req.disableTranslation  <= dis;
  endtask

  task automatic fillPage(input logic [35:0] vpn, input logic [7:0] pte);
    stepIdle();
    fillValid    <= 1'b1;
    fill.vpn     <= vpn;
    fill.ppn     <= {12'($urandom), $urandom};
    fill.pteBits <= pte;
  endtask

  task automatic flushAll();
    stepIdle();
    flush <= 1'b1;
  endtask

  // Only called with the pipeline empty, since the CSRs are quasi-static
  task automatic setCsr(input satpModeE mode, input logic [1:0] priv, input logic mprv,
                        input logic [1:0] mpp, input logic sum, input logic mxr);
    stepIdle();
    csr.satpMode <= mode;
    csr.privMode <= priv;
    csr.mprv     <= mprv;
    csr.mpp      <= mpp;
    csr.sum      <= sum;
    csr.mxr      <= mxr;
  endtask

  // Waits until every request sent so far has answered
  task automatic drainPipe();
    stepIdle();
    while (inFlight != 0 || respValid || reqValid) stepIdle();
  endtask

  // Canonical virtual address of a page under the chosen scheme
  function automatic logic [63:0] pageAddr(input logic [35:0] vpn, input logic [11:0] off,
                                           input logic sv39);
    return sv39 ? {{25{vpn[26]}}, vpn[26:0], off} : {{16{vpn[35]}}, vpn, off};
  endfunction

  function automatic logic [1:0] pickPriv(input int unsigned r);
    case (r % 3)
      0:       return privModeU;
      1:       return privModeS;
      default: return privModeM;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned seed;
    logic [35:0] vpn;
    logic [63:0] va;
    logic [1:0]  mppList [3];
    seed = 32'h3e9be3b2;
    void'($urandom(seed));
    csr       = '0;
    reqValid  = 1'b0;
    req       = '0;
    fillValid = 1'b0;
    fill      = '0;
    flush     = 1'b0;
    mppList   = '{privModeU, privModeS, privModeM};
    @(posedge rstN);

    // Translation off through Bare mode, M mode and the per-request bypass
    setCsr(modeBare, privModeS, 1'b0, privModeU, 1'b0, 1'b0);
    repeat (4) sendReq({$urandom, $urandom}, 1'b1, 1'b0, 1'b0);
    drainPipe();
    setCsr(modeSv39, privModeM, 1'b0, privModeU, 1'b0, 1'b0);
    repeat (4) sendReq({$urandom, $urandom}, 1'b0, 1'b1, 1'b0);
    drainPipe();
    setCsr(modeSv48, privModeS, 1'b0, privModeU, 1'b0, 1'b0);
    repeat (4) sendReq({$urandom, $urandom}, 1'b1, 1'b1, 1'b1);
    drainPipe();

    // Sv39 fill of every entry, a back-to-back stream, then one eviction
    setCsr(modeSv39, privModeS, 1'b0, privModeU, 1'b0, 1'b0);
    for (int i = 0; i < TLB_ENTRIES; i++) fillPage({9'd0, 27'h100 + 27'(i)}, PTE_RW);
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      sendReq(pageAddr({9'd0, 27'h100 + 27'(i)}, 12'($urandom), 1'b1),
              1'($urandom), 1'($urandom), 1'b0);
    end
    fillPage({9'd0, 27'h100 + 27'(TLB_ENTRIES)}, PTE_RW);
    sendReq(pageAddr({9'd0, 27'h100}, 12'h0, 1'b1), 1'b1, 1'b0, 1'b0);
    sendReq(pageAddr({9'd0, 27'h100 + 27'(TLB_ENTRIES)}, 12'hABC, 1'b1), 1'b1, 1'b0, 1'b0);
    drainPipe();

    // Sv48 pages in the upper half of the address space
    flushAll();
    setCsr(modeSv48, privModeS, 1'b0, privModeU, 1'b0, 1'b0);
    for (int i = 0; i < TLB_ENTRIES; i++) fillPage({9'h1F0, 27'h200 + 27'(i)}, PTE_RW);
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      sendReq(pageAddr({9'h1F0, 27'h200 + 27'(i)}, 12'($urandom), 1'b0),
              1'($urandom), 1'($urandom), 1'b0);
    end
    drainPipe();

    // Unfilled pages miss, and a response formed during a flush keeps miss low
    for (int i = 0; i < 4; i++) sendReq(pageAddr({9'h1F0, 27'h7000 + 27'(i)}, 12'h0, 1'b0),
                                        1'b1, 1'b0, 1'b0);
    sendReq(pageAddr({9'h1F0, 27'h7100}, 12'h0, 1'b0), 1'b0, 1'b1, 1'b0);
    stepIdle();
    flushAll();
    for (int i = 0; i < 4; i++) sendReq(pageAddr({9'h1F0, 27'h200 + 27'(i)}, 12'h0, 1'b0),
                                        1'b1, 1'b0, 1'b0);
    drainPipe();

    // Upper bits canonical for Sv48 but not for Sv39
    setCsr(modeSv39, privModeS, 1'b0, privModeU, 1'b0, 1'b0);
    fillPage({9'd0, 27'h0ABCD}, PTE_RW);
    va = {16'hFFFF, 9'h1FF, 27'h0ABCD, 12'h123};
    sendReq(va, 1'b1, 1'b0, 1'b0);
    drainPipe();
    flushAll();
    setCsr(modeSv48, privModeS, 1'b0, privModeU, 1'b0, 1'b0);
    fillPage({9'h1FF, 27'h0ABCD}, PTE_RW);
    sendReq(va, 1'b1, 1'b0, 1'b0);
    // The reverse case, bit 47 high with zeros above it
    sendReq({16'h0000, 9'h1FF, 27'h0ABCD, 12'h456}, 1'b1, 1'b0, 1'b0);
    drainPipe();

    // MPRV from M mode takes each MPP in turn against a user page
    flushAll();
    fillPage({9'd0, 27'h0CAFE}, PTE_RW | 8'h10);
    for (int i = 0; i < 3; i++) begin
      setCsr(modeSv39, privModeM, 1'b1, mppList[i], 1'b0, 1'b0);
      sendReq(pageAddr({9'd0, 27'h0CAFE}, 12'h010, 1'b1), 1'b1, 1'b0, 1'b0);
      drainPipe();
    end

    // Random permission bits, privileges and access kinds against one fresh page
    for (int n = 0; n < RANDOM_ROUNDS; n++) begin
      flushAll();
      vpn = {10'd0, 26'($urandom)};
      fillPage(vpn, 8'($urandom));
      setCsr(($urandom % 2) ? modeSv39 : modeSv48, pickPriv($urandom), 1'($urandom),
             pickPriv($urandom), 1'($urandom), 1'($urandom));
      sendReq(pageAddr(vpn, 12'($urandom), 1'b1), 1'($urandom), 1'($urandom), 1'b0);
      drainPipe();
    end

    if (checkError) begin
      failRun("A response check failed during the run");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dataTlb.f
hw/tlbPkg.sv
hw/tlbRequestStage.sv
hw/tlbCam.sv
hw/tlbControl.sv
hw/dataTlb.sv
tests/tlbClock.sv
tests/dataTlbChecks.sv
tests/dataTlbTb.sv
